//--- project.f
hw/mcu_cfg_pkg.sv
hw/isa_pkg.sv
hw/board_support.sv
hw/prog_mem.sv
hw/fetch_stage.sv
hw/exec_stage.sv
hw/fpga_mcu_wrapper.sv
+incdir+tests
tests/tb_fpga_mcu_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall -Wno-fatal
TOP       ?= tb_fpga_mcu_wrapper
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_tasks.svh
// ==============================
// load, run and exit check tasks, included
// in the body of the testbench module
// ==============================
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// writes prog[] from address 0 while run_i is low
task automatic load_program();
  for (int i = 0; i < prog.size(); i++) begin
    prog_we_i   = 1'b1;
    prog_addr_i = addr_w'(i);
    prog_data_i = instr_t'(prog[i]);
    @(posedge clk);
    #1;
  end
  prog_we_i = 1'b0;
endtask

// cycles counts the edges from raising run_i to exit
task automatic run_and_wait(input int limit, output int cycles);
  gpio_seen.delete();
  run_i = 1'b1;
  cycles = 0;
  while (!exit_valid_o && cycles < limit) begin
    @(posedge clk);
    #1;
    cycles++;
  end
  if (!exit_valid_o) begin
    report_error($sformatf("exit_valid_o did not rise within %0d cycles", limit));
  end
endtask

task automatic check_exit();
  logic [data_w-1:0] expected;
  expected = model_exit(4 * mem_depth);
  expect_eq(32'(exit_valid_o), 32'd1, "exit_valid_o");
  expect_eq(32'(exit_value_o), 32'(expected), "exit_value_o");
endtask

`endif

//--- tests/tb_fpga_mcu_wrapper.sv
// ==============================
// directed testbench for the board wrapper, with a
// reference model of the accumulator instruction set
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_mcu_wrapper
  import mcu_cfg_pkg::*;
  import isa_pkg::*;
();

  localparam int clk_period       = 100;
  localparam int led_len          = 4;
  localparam int limit_straight   = 40;
  localparam int limit_loop       = 60;
  localparam int heartbeat_cycles = 64;
  // ten straight runs, one loop, loads, stops and reset
  localparam int watchdog_cycles  = 10 * limit_straight + limit_loop + heartbeat_cycles
                                    + 12 * mem_depth + 100;

  logic              clk;
  logic              rst_n;
  logic              run_i;
  logic              prog_we_i;
  logic [addr_w-1:0] prog_addr_i;
  instr_t            prog_data_i;
  logic [gpio_w-1:0] gpio_o;
  logic [data_w-1:0] exit_value_o;
  logic              exit_valid_o;
  logic              rst_led_o;
  logic              clk_led_o;
  logic              clk_o;

  logic [15:0]       prog[$];
  logic [gpio_w-1:0] gpio_seen[$];
  logic [gpio_w-1:0] exp_gpio[$];
  logic [31:0]       lcg_state = 32'h319a5ef9;
  int                err_count = 0;
  int                test_count = 0;
  int                fail_count = 0;

  fpga_mcu_wrapper #(
    .led_count_len(led_len)
  ) dut (
    .clk_i       (clk),
    .rst_n       (rst_n),
    .run_i       (run_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .gpio_o      (gpio_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o),
    .clk_o       (clk_o)
  );

  always #(clk_period / 2) clk = ~clk;

  // every change of the port, cleared at each run start
  always @(gpio_o) begin
    gpio_seen.push_back(gpio_o);
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [15:0] encode(input opcode_e op, input logic [imm_w-1:0] imm);
    return {op, imm};
  endfunction

  // interprets prog[] and collects the expected gpio changes
  function automatic logic [data_w-1:0] model_exit(input int max_steps);
    logic [data_w-1:0] acc;
    logic [gpio_w-1:0] gpio;
    logic [15:0]       word;
    int                pc;
    acc = '0;
    gpio = '0;
    pc = 0;
    exp_gpio.delete();
    for (int step = 0; step < max_steps; step++) begin
      if (pc >= prog.size()) begin
        break;
      end
      word = prog[pc];
      pc = pc + 1;
      case (word[15:12])
        op_ldi:  acc = data_w'(word[imm_w-1:0]);
        op_addi: acc = acc + data_w'(word[imm_w-1:0]);
        op_subi: acc = acc - data_w'(word[imm_w-1:0]);
        op_xori: acc = acc ^ data_w'(word[imm_w-1:0]);
        op_shl:  acc = acc << 1;
        op_gpio: begin
          if (acc[gpio_w-1:0] != gpio) begin
            gpio = acc[gpio_w-1:0];
            exp_gpio.push_back(gpio);
          end
        end
        op_bnz: begin
          if (acc != '0) begin
            pc = int'(word[addr_w-1:0]);
          end
        end
        op_exit: return acc;
        default: ;
      endcase
    end
    return acc;
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (err_count != errs_before) begin
      fail_count++;
      $display("test %-8s fail, %0d errors", name, err_count - errs_before);
    end else begin
      $display("test %-8s ok", name);
    end
  endtask

  task automatic stop_run();
    run_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic compare_gpio();
    expect_eq(32'(gpio_seen.size()), 32'(exp_gpio.size()), "gpio change count");
    for (int i = 0; i < gpio_seen.size() && i < exp_gpio.size(); i++) begin
      expect_eq(32'(gpio_seen[i]), 32'(exp_gpio[i]), $sformatf("gpio change %0d", i));
    end
  endtask

  `include "tb_tasks.svh"

  task automatic reset_state();
    int errs;
    errs = err_count;
    // synchronized reset releases on the second edge
    repeat (2) @(posedge clk);
    #1;
    expect_eq(32'(rst_led_o), 32'd1, "rst_led_o");
    expect_eq(32'(gpio_o), 32'd0, "gpio_o");
    expect_eq(32'(clk_led_o), 32'd0, "clk_led_o");
    expect_eq(32'(exit_valid_o), 32'd0, "exit_valid_o");
    @(negedge clk);
    #1;
    expect_eq(32'(clk_o), 32'd0, "clk_o low phase");
    @(posedge clk);
    #1;
    expect_eq(32'(clk_o), 32'd1, "clk_o high phase");
    end_test("reset", errs);
  endtask

  task automatic arith_program();
    int errs;
    int cycles;
    errs = err_count;
    // 5 - 7 wraps below zero
    prog = '{encode(op_ldi, 12'h005), encode(op_subi, 12'h007), encode(op_xori, 12'h0f0),
             encode(op_addi, 12'h123), encode(op_shl, 12'h000), encode(op_shl, 12'h000),
             encode(op_addi, 12'h001), encode(op_exit, 12'h000)};
    load_program();
    run_and_wait(limit_straight, cycles);
    check_exit();
    expect_eq(32'(cycles), 32'(3 + prog.size() - 1), "exit latency in cycles");
    stop_run();
    end_test("arith", errs);
  endtask

  task automatic gpio_and_run();
    int errs;
    int cycles;
    errs = err_count;
    prog = '{encode(op_ldi, 12'h012), encode(op_gpio, 12'h000), encode(op_ldi, 12'h034),
             encode(op_gpio, 12'h000), encode(op_addi, 12'h056), encode(op_gpio, 12'h000),
             encode(op_exit, 12'h000)};
    load_program();
    run_and_wait(limit_straight, cycles);
    check_exit();
    compare_gpio();
    expect_eq(32'(gpio_seen.size()), 32'd3, "distinct gpio writes");
    stop_run();
    expect_eq(32'(gpio_o), 32'd0, "gpio_o after run low");
    expect_eq(32'(exit_valid_o), 32'd0, "exit_valid_o after run low");
    end_test("gpio", errs);
  endtask

  task automatic branch_flush();
    int errs;
    int cycles;
    errs = err_count;
    // the words at 4 and 7 sit in the shadow of taken branches
    prog = '{encode(op_ldi, 12'h003), encode(op_gpio, 12'h000), encode(op_subi, 12'h001),
             encode(op_bnz, 12'h006), encode(op_addi, 12'h077), encode(op_exit, 12'h000),
             encode(op_bnz, 12'h001), encode(op_xori, 12'h0ff)};
    load_program();
    run_and_wait(limit_loop, cycles);
    check_exit();
    compare_gpio();
    expect_eq(32'(gpio_seen.size()), 32'd3, "loop gpio writes");
    stop_run();
    end_test("branch", errs);
  endtask

  task automatic random_programs();
    int          errs;
    int          n;
    int          cycles;
    logic [31:0] r;
    logic [3:0]  code;
    errs = err_count;
    for (int p = 0; p < 8; p++) begin
      prog.delete();
      n = 1 + int'(lcg_next() % 32'd20);
      for (int j = 0; j < n; j++) begin
        r = lcg_next();
        case (r[2:0])
          3'd0: code = op_nop;
          3'd1: code = op_ldi;
          3'd2: code = op_addi;
          3'd3: code = op_subi;
          3'd4: code = op_xori;
          3'd5: code = op_shl;
          3'd6: code = op_gpio;
          default: code = 4'hb;
        endcase
        prog.push_back({code, r[27:16]});
      end
      prog.push_back(encode(op_exit, 12'h000));
      load_program();
      run_and_wait(limit_straight, cycles);
      check_exit();
      compare_gpio();
      expect_eq(32'(cycles), 32'(3 + n), $sformatf("program %0d exit latency", p));
      stop_run();
    end
    end_test("random", errs);
  endtask

  task automatic heartbeat();
    int   errs;
    int   toggles;
    logic prev;
    errs = err_count;
    toggles = 0;
    prev = clk_led_o;
    repeat (heartbeat_cycles) begin
      @(posedge clk);
      #1;
      if (clk_led_o != prev) begin
        toggles++;
      end
      prev = clk_led_o;
    end
    expect_eq(32'(toggles), 32'(heartbeat_cycles / (1 << (led_len - 1))), "heartbeat toggles");
    end_test("heartbeat", errs);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    run_i = 1'b0;
    prog_we_i = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    arith_program();
    gpio_and_run();
    branch_flush();
    random_programs();
    heartbeat();
    $display("summary: %0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule : tb_fpga_mcu_wrapper

`default_nettype wire

//--- hw/fpga_mcu_wrapper.sv
// ==============================
// board top: board support logic beside the
// fetch/execute core and its program memory
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fpga_mcu_wrapper
  import mcu_cfg_pkg::*;
  import isa_pkg::*;
#(
  parameter int unsigned led_count_len = 24
) (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              run_i,
  input  logic              prog_we_i,
  input  logic [addr_w-1:0] prog_addr_i,
  input  instr_t            prog_data_i,
  output logic [gpio_w-1:0] gpio_o,
  output logic [data_w-1:0] exit_value_o,
  output logic              exit_valid_o,
  output logic              rst_led_o,
  output logic              clk_led_o,
  output logic              clk_o
);

  logic              clk_gen;
  logic              rst_sync_n;
  logic [addr_w-1:0] mem_addr;
  instr_t            mem_data;
  fetch_t            fetch;
  redirect_t         redirect;
  logic              halt;

  // board clock used directly, no clock wizard
  assign clk_gen = clk_i;
  assign clk_o   = clk_gen;

  board_support #(
    .led_count_len(led_count_len)
  ) u_board_support (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .rst_sync_n_o(rst_sync_n),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o)
  );

  prog_mem u_prog_mem (
    .clk_gen(clk_gen),
    .run_i  (run_i),
    .we_i   (prog_we_i),
    .waddr_i(prog_addr_i),
    .wdata_i(prog_data_i),
    .raddr_i(mem_addr),
    .rdata_o(mem_data)
  );

  fetch_stage u_fetch_stage (
    .clk_gen   (clk_gen),
    .rst_n     (rst_sync_n),
    .run_i     (run_i),
    .halt_i    (halt),
    .redirect_i(redirect),
    .mem_addr_o(mem_addr),
    .mem_data_i(mem_data),
    .fetch_o   (fetch)
  );

  exec_stage u_exec_stage (
    .clk_gen     (clk_gen),
    .rst_n       (rst_sync_n),
    .run_i       (run_i),
    .fetch_i     (fetch),
    .redirect_o  (redirect),
    .halt_o      (halt),
    .gpio_o      (gpio_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule : fpga_mcu_wrapper

`default_nettype wire

//--- hw/exec_stage.sv
// ==============================
// execute stage: accumulator ALU, branch resolution,
// GPIO register and exit registers
// ==============================
`timescale 1ns/1ps
`default_nettype none

module exec_stage
  import mcu_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic              clk_gen,
  input  logic              rst_n,
  input  logic              run_i,
  input  fetch_t            fetch_i,
  output redirect_t         redirect_o,
  output logic              halt_o,
  output logic [gpio_w-1:0] gpio_o,
  output logic [data_w-1:0] exit_value_o,
  output logic              exit_valid_o
);

  typedef enum logic {
    st_running,
    st_exited
  } state_e;

  state_e            state_q;
  opcode_e           op;
  logic [data_w-1:0] imm_ext;
  logic [data_w-1:0] acc_q;
  logic [gpio_w-1:0] gpio_q;
  logic [data_w-1:0] exit_value_q;

  assign op      = fetch_i.instr.opcode;
  assign imm_ext = data_w'(fetch_i.instr.imm);

  // resolved in the same cycle, fetch reacts at the next edge
  always_comb begin
    redirect_o.take   = fetch_i.valid && (op == op_bnz) && (acc_q != '0);
    redirect_o.target = fetch_i.instr.imm[addr_w-1:0];
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= st_running;
      acc_q        <= '0;
      gpio_q       <= '0;
      exit_value_q <= '0;
    end else if (!run_i) begin
      state_q      <= st_running;
      acc_q        <= '0;
      gpio_q       <= '0;
      exit_value_q <= '0;
    end else if (fetch_i.valid) begin
      case (op)
        op_ldi:  acc_q <= imm_ext;
        op_addi: acc_q <= acc_q + imm_ext;
        op_subi: acc_q <= acc_q - imm_ext;
        op_xori: acc_q <= acc_q ^ imm_ext;
        op_shl:  acc_q <= {acc_q[data_w-2:0], 1'b0};
        op_gpio: gpio_q <= acc_q[gpio_w-1:0];
        op_exit: begin
          state_q      <= st_exited;
          exit_value_q <= acc_q;
        end
        // op_nop, op_bnz and unused codes leave the registers alone
        default: ;
      endcase
    end
  end

  assign exit_valid_o = (state_q == st_exited);
  assign halt_o       = exit_valid_o;
  assign gpio_o       = gpio_q;
  assign exit_value_o = exit_value_q;

  a_quiet_after_exit : assert property (
    @(posedge clk_gen) disable iff (!rst_n) !(fetch_i.valid && exit_valid_o)
  ) else $error("valid instruction after exit");

  // back-to-back valid items are sequential unless a branch was taken
  a_pc_sequence : assert property (
    @(posedge clk_gen) disable iff (!rst_n || !run_i)
    fetch_i.valid && !redirect_o.take ##1 fetch_i.valid
      |-> fetch_i.pc == addr_w'($past(fetch_i.pc) + 1'b1)
  ) else $error("fetch pc out of sequence");

endmodule : exec_stage

`default_nettype wire

//--- hw/fetch_stage.sv
// ==============================
// fetch stage: pc, sequential issue, branch redirect
// and halt, one instruction handed to execute per cycle
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import mcu_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic              clk_gen,
  input  logic              rst_n,
  input  logic              run_i,
  input  logic              halt_i,
  input  redirect_t         redirect_i,
  output logic [addr_w-1:0] mem_addr_o,
  input  instr_t            mem_data_i,
  output fetch_t            fetch_o
);

  logic              run_q;
  logic              issue;
  logic [addr_w-1:0] pc_q;
  logic              rd_valid_q;
  logic [addr_w-1:0] rd_pc_q;

  // issue starts the cycle after run is first seen high
  assign issue      = run_i && run_q && !halt_i;
  assign mem_addr_o = pc_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      run_q      <= 1'b0;
      pc_q       <= '0;
      rd_valid_q <= 1'b0;
      rd_pc_q    <= '0;
    end else begin
      run_q <= run_i;
      // a taken branch kills the read now in flight
      rd_valid_q <= issue && !redirect_i.take;
      rd_pc_q    <= pc_q;
      if (!run_i) begin
        pc_q <= '0;
      end else if (redirect_i.take) begin
        pc_q <= redirect_i.target;
      end else if (issue) begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  // the word fetched alongside op_exit is dropped here
  always_comb begin
    fetch_o.valid = rd_valid_q && !halt_i;
    fetch_o.pc    = rd_pc_q;
    fetch_o.instr = mem_data_i;
  end

  a_no_redirect_when_halted : assert property (
    @(posedge clk_gen) disable iff (!rst_n) !(redirect_i.take && halt_i)
  ) else $error("branch redirect while halted");

endmodule : fetch_stage

`default_nettype wire

//--- hw/prog_mem.sv
// ==============================
// program memory, loaded while stopped and read
// by the fetch stage with one cycle of latency
// ==============================
`timescale 1ns/1ps
`default_nettype none

module prog_mem
  import mcu_cfg_pkg::*;
  import isa_pkg::*;
(
  input  logic              clk_gen,
  input  logic              run_i,
  input  logic              we_i,
  input  logic [addr_w-1:0] waddr_i,
  input  instr_t            wdata_i,
  input  logic [addr_w-1:0] raddr_i,
  output instr_t            rdata_o
);

  instr_t mem_q [mem_depth];

  always_ff @(posedge clk_gen) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
    rdata_o <= mem_q[raddr_i];
  end

  // loading is only legal while the core is stopped
  a_no_load_while_running : assert property (
    @(posedge clk_gen) !(we_i && run_i)
  ) else $error("program write while run_i is high");

endmodule : prog_mem

`default_nettype wire

//--- hw/board_support.sv
// ==============================
// reset synchronizer, reset LED and heartbeat
// counter for the board wrapper
// ==============================
`timescale 1ns/1ps
`default_nettype none

module board_support #(
  parameter int unsigned led_count_len = 24
) (
  input  logic clk_gen,
  input  logic rst_n,
  output logic rst_sync_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic [1:0]               sync_q;
  logic [led_count_len-1:0] count_q;

  if (led_count_len < 2) begin : gen_len_check
    $error("led_count_len must be at least 2");
  end

  // asserts at once, releases on the second edge
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = sync_q[1];
  assign rst_led_o    = sync_q[1];

  // top bit toggles every 2**(len-1) cycles
  always_ff @(posedge clk_gen or negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign clk_led_o = count_q[led_count_len-1];

endmodule : board_support

`default_nettype wire

//--- hw/isa_pkg.sv
// ==============================
// instruction set and the records passed between
// the fetch and execute stages
// ==============================
`default_nettype none

package isa_pkg;
  import mcu_cfg_pkg::*;

  // unlisted codes decode as op_nop
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ldi  = 4'h1,
    op_addi = 4'h2,
    op_subi = 4'h3,
    op_xori = 4'h4,
    op_shl  = 4'h5,
    op_gpio = 4'h6,
    op_bnz  = 4'h7,
    op_exit = 4'h8
  } opcode_e;

  // 16-bit word, opcode in the top nibble
  typedef struct packed {
    opcode_e          opcode;
    logic [imm_w-1:0] imm;
  } instr_t;

  // fetch -> execute, one per cycle
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] pc;
    instr_t            instr;
  } fetch_t;

  // execute -> fetch, take is a single-cycle pulse
  typedef struct packed {
    logic              take;
    logic [addr_w-1:0] target;
  } redirect_t;

endpackage : isa_pkg

`default_nettype wire

//--- hw/mcu_cfg_pkg.sv
// ==============================
// sizes of the memory, data path and GPIO port
// imported by the ISA package and every RTL module
// ==============================
`default_nettype none

package mcu_cfg_pkg;

  // accumulator and exit value
  localparam int unsigned data_w = 16;

  // immediate field of an instruction
  localparam int unsigned imm_w = 12;

  // output port driven by op_gpio
  localparam int unsigned gpio_w = 8;

  // program memory, in instruction words
  localparam int unsigned mem_depth = 64;
  localparam int unsigned addr_w = $clog2(mem_depth);

endpackage : mcu_cfg_pkg

`default_nettype wire
